// ==== Makefile ====
SIM := obj_dir/Vcsr_periph_tb
SRCS := $(shell grep -v '^+' tb.f) dv/csr_periph_model.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) tb.f
	verilator --binary --timing -Wall -f tb.f --top-module csr_periph_tb -Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/csr_periph_model.svh ====
// CSR subsystem reference model
`ifndef CSR_PERIPH_MODEL_SVH
`define CSR_PERIPH_MODEL_SVH

logic [31:0] lfsr_state = 32'ha134;
logic [31:0] cells [NumCells];
logic [BtnWidth-1:0] cur_btn;
logic [7:0] exp_bytes [$];

// galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
  logic out;
  out = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (out) begin
    lfsr_state = lfsr_state ^ 32'h80200003;
  end
  return out;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = 32'd0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_bit()};
  end
  return r;
endfunction

// applies one access, returns old value and expected err
task automatic model_access(input csr_op_t op, input csr_addr_t addr,
                            input logic [31:0] operand,
                            output logic [31:0] old, output logic err);
  int idx;
  logic wr;
  old = 32'd0;
  err = 1'b0;
  wr = (op == csr_rw) || (operand != 32'd0);
  idx = int'(addr) - int'(CellBase);
  if (idx >= 0 && idx < NumCells) begin
    old = cells[idx];
    if (wr) begin
      case (op)
        csr_rs:  cells[idx] = old | operand;
        csr_rc:  cells[idx] = old & ~operand;
        default: cells[idx] = operand;
      endcase
      if (idx == TxIdx) begin
        exp_bytes.push_back(cells[idx][7:0]);
      end
    end
  end else if (addr == BtnAddr) begin
    old = 32'(cur_btn);
  end else if (addr != TxStatAddr) begin
    err = 1'b1;
  end
endtask

`endif

// ==== dv/csr_periph_tb.sv ====
// CSR subsystem testbench
`timescale 1ns/1ps

module csr_periph_tb import csr_pkg::*, periph_pkg::*; ();

  localparam int FifoDepth = 8;

  logic clk;
  logic arst_n;
  logic cmd_valid;
  csr_cmd_t cmd;
  logic [BtnWidth-1:0] btn;
  logic rsp_valid;
  csr_rsp_t rsp;
  logic [LedWidth-1:0] led;
  logic tx;

  logic [31:0] exp_data [$];
  logic exp_err [$];
  logic [31:0] exp_mask [$];
  logic [7:0] rx_bytes [$];
  logic rx_on;
  csr_rsp_t last_rsp;
  int errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int errs_at_start;

  `include "csr_periph_model.svh"

  csr_periph_top #(.FifoDepth(FifoDepth), .ResetDivisor(32'd3)) csr_periph_top_inst (
    .clk, .arst_n, .cmd_valid, .cmd, .btn, .rsp_valid, .rsp, .led, .tx
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // responses come back in order, two cycles after their command
  initial begin
    logic [1:0] valid_hist;
    valid_hist = 2'b00;
    forever begin
      @(negedge clk);
      if (arst_n) begin
        assert (rsp_valid == valid_hist[1]) else begin
          $display("** Error at %0t: rsp_valid %b, expected %b", $time, rsp_valid,
                   valid_hist[1]);
          errors++;
        end
        valid_hist = {valid_hist[0], cmd_valid};
      end
      if (arst_n && rsp_valid) begin
        if (exp_data.size() == 0) begin
          $display("response arrived at %0t with no command outstanding", $time);
          errors++;
        end else begin
          logic [31:0] d;
          logic [31:0] m;
          logic e;
          d = exp_data.pop_front();
          m = exp_mask.pop_front();
          e = exp_err.pop_front();
          assert (((rsp.data & m) == (d & m)) && (rsp.err == e)) else begin
            $display("** Error at %0t: rsp %h/%0b, expected %h/%0b", $time,
                     rsp.data, rsp.err, d, e);
            errors++;
          end
        end
        last_rsp = rsp;
      end
    end
  end

  // UART receiver, samples mid-bit from the start edge
  initial begin
    logic [7:0] b;
    int len;
    forever begin
      @(negedge clk);
      if (arst_n && rx_on && !tx) begin
        len = int'(cells[BaudIdx][15:0]) + 1;
        repeat (len / 2) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
          repeat (len) @(negedge clk);
          b[i] = tx;
        end
        repeat (len) @(negedge clk);
        if (!tx) begin
          $display("UART stop bit missing at %0t", $time);
          errors++;
        end
        rx_bytes.push_back(b);
      end
    end
  end

  task automatic send(input csr_op_t op, input logic use_imm, input csr_addr_t addr,
                      input logic [31:0] rs1, input logic [4:0] zimm,
                      input logic [31:0] mask);
    csr_cmd_t c;
    logic [31:0] old;
    logic err;
    c.op = op;
    c.use_imm = use_imm;
    c.addr = addr;
    c.rs1_data = rs1;
    c.zimm = zimm;
    model_access(op, addr, use_imm ? 32'(zimm) : rs1, old, err);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd <= c;
    exp_data.push_back(old);
    exp_err.push_back(err);
    exp_mask.push_back(mask);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      cmd_valid <= 1'b0;
    end
  endtask

  task automatic drain_rsp();
    int t;
    t = 0;
    while (exp_data.size() != 0 && t < 50) begin
      @(posedge clk);
      cmd_valid <= 1'b0;
      t++;
    end
    if (exp_data.size() != 0) begin
      $display("timed out waiting for %0d responses", exp_data.size());
      errors++;
    end
  endtask

  task automatic read_status();
    send(csr_rs, 1'b0, TxStatAddr, 32'd0, 5'd0, 32'd0);
    drain_rsp();
  endtask

  task automatic wait_rx(input int n, input int limit);
    int t;
    t = 0;
    while (rx_bytes.size() < n && t < limit) begin
      @(posedge clk);
      t++;
    end
    if (rx_bytes.size() < n) begin
      $display("timed out waiting for UART frames, got %0d of %0d", rx_bytes.size(), n);
      errors++;
    end
  endtask

  // FIFO empty and last frame done, then forget old bytes
  task automatic drain_uart();
    int t;
    t = 0;
    read_status();
    while (!last_rsp.data[5] && t < 200) begin
      idle(40);
      read_status();
      t++;
    end
    if (!last_rsp.data[5]) begin
      $display("timed out waiting for the transmit FIFO to empty");
      errors++;
    end
    idle(400);
    rx_bytes.delete();
    exp_bytes.delete();
  endtask

  task automatic finish_test(input string name);
    if (errors == errs_at_start) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL (%0d errors)", name, errors - errs_at_start);
    end
    errs_at_start = errors;
  endtask

  initial begin
    logic [1:0] sel;
    logic [31:0] rs1;
    logic [4:0] zimm;
    csr_op_t op;
    csr_addr_t a;
    arst_n = 1'b0;
    cmd_valid = 1'b0;
    cmd = '0;
    btn = '0;
    cur_btn = '0;
    rx_on = 1'b0;
    for (int i = 0; i < NumCells; i++) begin
      cells[i] = (i == BaudIdx) ? 32'd3 : 32'd0;
    end
    errs_at_start = 0;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;

    for (int i = 0; i < 16; i++) begin
      @(negedge clk);
      assert (led == '0 && tx && !rsp_valid) else begin
        $display("** Error at %0t: reset state led %h tx %b rsp_valid %b", $time,
                 led, tx, rsp_valid);
        errors++;
      end
    end
    finish_test("reset");

    for (int i = 0; i < 200; i++) begin
      sel = 2'(rand_bits(2));
      op = (sel == 2'd1) ? csr_rs : (sel == 2'd2) ? csr_rc : csr_rw;
      sel = 2'(rand_bits(2));
      rs1 = rand_bits(32);
      zimm = 5'(rand_bits(5));
      // short frames keep the UART draining
      if (int'(sel) == BaudIdx) begin
        rs1 = rs1 & 32'hf;
        zimm = zimm & 5'hf;
      end
      send(op, 1'(rand_bits(1)), CellBase + 12'(sel), rs1, zimm, 32'hffffffff);
      if (rand_bits(2) == 32'd0) begin
        idle(1);
      end
    end
    drain_rsp();
    @(negedge clk);
    assert (led == cells[LedIdx][LedWidth-1:0]) else begin
      $display("** Error at %0t: led %h, expected %h", $time, led, cells[LedIdx][7:0]);
      errors++;
    end
    finish_test("random_cells");

    drain_uart();
    // divisor no longer moves under a running frame
    rx_on = 1'b1;
    send(csr_rs, 1'b0, CellBase + 12'(TxIdx), 32'd0, 5'd0, 32'hffffffff);
    send(csr_rc, 1'b1, CellBase + 12'(TxIdx), 32'd5, 5'd0, 32'hffffffff);
    send(csr_rw, 1'b0, CellBase + 12'(ScratchIdx), rand_bits(32), 5'd0, 32'hffffffff);
    send(csr_rs, 1'b0, CellBase + 12'(ScratchIdx), rand_bits(32), 5'd0, 32'hffffffff);
    send(csr_rc, 1'b1, CellBase + 12'(ScratchIdx), 32'd0, 5'(rand_bits(5)), 32'hffffffff);
    send(csr_rs, 1'b1, CellBase + 12'(ScratchIdx), 32'd0, 5'd0, 32'hffffffff);
    send(csr_rs, 1'b1, CellBase + 12'(ScratchIdx), 32'd0, 5'd0, 32'hffffffff);
    drain_rsp();
    idle(200);
    assert (rx_bytes.size() == 0) else begin
      $display("** Error at %0t: %0d bytes sent by a non-writing op", $time,
               rx_bytes.size());
      errors++;
    end
    finish_test("zero_operand_and_back_to_back");

    for (int i = 0; i < 20; i++) begin
      a = 12'(rand_bits(12));
      if (a[11:4] == 8'h7c || a[11:4] == 8'h7d) begin
        a = a ^ 12'h100;
      end
      send(csr_rs, 1'b0, a, rand_bits(32), 5'd0, 32'hffffffff);
      @(posedge clk);
      btn <= BtnWidth'(rand_bits(BtnWidth));
      cmd_valid <= 1'b0;
      idle(3);
      cur_btn = btn;
      send(csr_rs, 1'b0, BtnAddr, 32'd0, 5'd0, 32'hffffffff);
    end
    drain_rsp();
    finish_test("unmapped_and_buttons");

    send(csr_rw, 1'b0, TxStatAddr, 32'd1, 5'd0, 32'd0);
    send(csr_rw, 1'b0, CellBase + 12'(BaudIdx), 32'd5, 5'd0, 32'hffffffff);
    drain_uart();
    for (int i = 0; i < 6; i++) begin
      send(csr_rw, 1'b0, CellBase + 12'(TxIdx), rand_bits(32), 5'd0, 32'hffffffff);
    end
    drain_rsp();
    wait_rx(6, 6 * 6 * 10 + 200);
    for (int i = 0; i < rx_bytes.size() && i < 6; i++) begin
      assert (rx_bytes[i] == exp_bytes[i]) else begin
        $display("** Error at %0t: frame %0d byte %h, expected %h", $time, i,
                 rx_bytes[i], exp_bytes[i]);
        errors++;
      end
    end
    finish_test("uart_frames");

    send(csr_rw, 1'b0, CellBase + 12'(BaudIdx), 32'd40, 5'd0, 32'hffffffff);
    drain_uart();
    for (int i = 0; i < FifoDepth + 4; i++) begin
      send(csr_rw, 1'b0, CellBase + 12'(TxIdx), rand_bits(32), 5'd0, 32'hffffffff);
    end
    read_status();
    assert (last_rsp.data[4]) else begin
      $display("** Error at %0t: overflow not set, status %h", $time, last_rsp.data);
      errors++;
    end
    send(csr_rw, 1'b0, TxStatAddr, 32'd1, 5'd0, 32'd0);
    read_status();
    assert (!last_rsp.data[4]) else begin
      $display("** Error at %0t: overflow not cleared, status %h", $time, last_rsp.data);
      errors++;
    end
    // the serializer holds one byte, the FIFO the next FifoDepth
    wait_rx(FifoDepth + 1, (FifoDepth + 1) * 41 * 10 + 400);
    idle(41 * 10 * 2);
    assert (rx_bytes.size() == FifoDepth + 1) else begin
      $display("** Error at %0t: %0d frames, expected %0d", $time, rx_bytes.size(),
               FifoDepth + 1);
      errors++;
    end
    for (int i = 0; i < rx_bytes.size() && i <= FifoDepth; i++) begin
      assert (rx_bytes[i] == exp_bytes[i]) else begin
        $display("** Error at %0t: frame %0d byte %h, expected %h", $time, i,
                 rx_bytes[i], exp_bytes[i]);
        errors++;
      end
    end
    finish_test("fifo_overflow");

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
             errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== source/csr_cell.sv ====
// read/write CSR cell
`timescale 1ns/1ps

module csr_cell import csr_pkg::*; #(
  parameter csr_addr_t   Addr       = 12'h000,
  parameter logic [31:0] ResetValue = 32'd0
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        req_valid,
  input  csr_req_t    req,
  output logic        hit,
  output logic [31:0] rdata,
  output logic [31:0] value,
  output logic        wr_pulse
);

  logic [31:0] next_value;
  logic        do_write;

  assign hit      = req_valid && (req.addr == Addr);
  assign do_write = hit && req.write;

  // old value, zero when not addressed so the collector can OR
  assign rdata = hit ? value : 32'd0;

  always_comb begin
    case (req.op)
      csr_rw:  next_value = req.operand;
      csr_rs:  next_value = value | req.operand;
      csr_rc:  next_value = value & ~req.operand;
      default: next_value = value;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      value    <= ResetValue;
      wr_pulse <= 1'b0;
    end else begin
      // pulse lines up with the new value
      wr_pulse <= do_write;
      if (do_write) begin
        value <= next_value;
      end
    end
  end

endmodule

// ==== source/csr_collect.sv ====
// CSR read collector
`timescale 1ns/1ps

module csr_collect import csr_pkg::*, periph_pkg::*; (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       req_valid,
  input  csr_addr_t                  addr,
  input  logic [NumCells-1:0]        cell_hit,
  input  logic [NumCells-1:0][31:0]  cell_rdata,
  input  logic [BtnWidth-1:0]        btn,
  input  tx_stat_t                   tx_stat,
  output logic                       rsp_valid,
  output csr_rsp_t                   rsp
);

  logic [BtnWidth-1:0] btn_meta;
  logic [BtnWidth-1:0] btn_sync;
  logic [31:0]         cell_data;
  csr_rsp_t            rsp_next;

  // buttons are asynchronous to clk
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      btn_meta <= '0;
      btn_sync <= '0;
    end else begin
      btn_meta <= btn;
      btn_sync <= btn_meta;
    end
  end

  always_comb begin
    cell_data = 32'd0;
    // at most one cell hits, the rest drive zero
    for (int i = 0; i < NumCells; i++) begin
      cell_data = cell_data | cell_rdata[i];
    end
    rsp_next.data = 32'd0;
    rsp_next.err  = 1'b0;
    if (|cell_hit) begin
      rsp_next.data = cell_data;
    end else if (addr == BtnAddr) begin
      rsp_next.data = 32'(btn_sync);
    end else if (addr == TxStatAddr) begin
      rsp_next.data = 32'(tx_stat);
    end else begin
      rsp_next.err = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin
      rsp <= rsp_next;
    end
  end

endmodule

// ==== source/csr_issue.sv ====
// CSR issue stage
`timescale 1ns/1ps

module csr_issue import csr_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     cmd_valid,
  input  csr_cmd_t cmd,
  output logic     req_valid,
  output csr_req_t req
);

  logic [31:0] operand;
  logic        does_write;

  always_comb begin
    // zimm is the rs1 field, zero extended
    if (cmd.use_imm) begin
      operand = 32'(cmd.zimm);
    end else begin
      operand = cmd.rs1_data;
    end
    // set/clear with nothing to set or clear is a pure read
    does_write = (cmd.op == csr_rw) || (operand != 32'd0);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= cmd_valid;
    end
  end

  // payload only moves with a valid command
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      req.op      <= cmd.op;
      req.addr    <= cmd.addr;
      req.operand <= operand;
      req.write   <= does_write;
    end
  end

endmodule

// ==== source/csr_periph_top.sv ====
// CSR peripheral subsystem
`timescale 1ns/1ps

module csr_periph_top import csr_pkg::*, periph_pkg::*; #(
  parameter int          FifoDepth    = 8,
  parameter logic [31:0] ResetDivisor = 32'd3
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                cmd_valid,
  input  csr_cmd_t            cmd,
  input  logic [BtnWidth-1:0] btn,
  output logic                rsp_valid,
  output csr_rsp_t            rsp,
  output logic [LedWidth-1:0] led,
  output logic                tx
);

  logic                      req_valid;
  csr_req_t                  req;
  logic [NumCells-1:0]       cell_hit;
  logic [NumCells-1:0]       cell_wr;
  logic [NumCells-1:0][31:0] cell_rdata;
  logic [NumCells-1:0][31:0] cell_value;
  tx_stat_t                  tx_stat;
  logic                      ovf_clear;
  logic                      fifo_have_data;
  logic [7:0]                fifo_data;
  logic                      uart_next;

  csr_issue issue_inst (
    .clk,
    .arst_n,
    .cmd_valid,
    .cmd,
    .req_valid,
    .req
  );

  // cell i answers at CellBase + i
  for (genvar i = 0; i < NumCells; i++) begin : g_cell
    csr_cell #(
      .Addr(CellBase + csr_addr_t'(i)),
      .ResetValue((i == BaudIdx) ? ResetDivisor : 32'd0)
    ) cell_inst (
      .clk,
      .arst_n,
      .req_valid,
      .req,
      .hit(cell_hit[i]),
      .rdata(cell_rdata[i]),
      .value(cell_value[i]),
      .wr_pulse(cell_wr[i])
    );
  end

  csr_collect collect_inst (
    .clk,
    .arst_n,
    .req_valid,
    .addr(req.addr),
    .cell_hit,
    .cell_rdata,
    .btn,
    .tx_stat,
    .rsp_valid,
    .rsp
  );

  // any write to the status address clears overflow
  assign ovf_clear = req_valid && req.write && (req.addr == TxStatAddr);

  tx_fifo #(
    .FifoDepth(FifoDepth)
  ) fifo_inst (
    .clk,
    .arst_n,
    .push(cell_wr[TxIdx]),
    .push_data(cell_value[TxIdx][7:0]),
    .ovf_clear,
    .pop(uart_next),
    .have_data(fifo_have_data),
    .data(fifo_data),
    .stat(tx_stat)
  );

  uart_tx uart_inst (
    .clk,
    .arst_n,
    .divisor(cell_value[BaudIdx][15:0]),
    .have_data(fifo_have_data),
    .data(fifo_data),
    .tx,
    .next(uart_next)
  );

  assign led = cell_value[LedIdx][LedWidth-1:0];

endmodule

// ==== source/csr_pkg.sv ====
// CSR access types
package csr_pkg;

  // low two bits of the RISC-V funct3 field
  typedef enum logic [1:0] {
    csr_rw = 2'b01,
    csr_rs = 2'b10,
    csr_rc = 2'b11
  } csr_op_t;

  typedef logic [11:0] csr_addr_t;

  // command as it leaves the core's decode stage
  typedef struct packed {
    csr_op_t     op;
    logic        use_imm;
    csr_addr_t   addr;
    logic [31:0] rs1_data;
    logic [4:0]  zimm;
  } csr_cmd_t;

  // issued request, operand already selected
  typedef struct packed {
    csr_op_t     op;
    csr_addr_t   addr;
    logic [31:0] operand;
    // clear for set/clear with a zero operand
    logic        write;
  } csr_req_t;

  typedef struct packed {
    logic [31:0] data;
    // no register answered the address
    logic        err;
  } csr_rsp_t;

endpackage

// ==== source/periph_pkg.sv ====
// peripheral address map
package periph_pkg;

  // bank of read/write cells
  localparam int NumCells = 4;
  localparam csr_pkg::csr_addr_t CellBase = 12'h7c0;

  localparam int LedIdx     = 0;
  localparam int ScratchIdx = 1;
  localparam int BaudIdx    = 2;
  localparam int TxIdx      = 3;

  // read-only registers outside the cell bank
  localparam csr_pkg::csr_addr_t BtnAddr    = 12'h7d0;
  localparam csr_pkg::csr_addr_t TxStatAddr = 12'h7d1;

  localparam int LedWidth = 8;
  localparam int BtnWidth = 4;

  // transmit status, read back zero extended
  typedef struct packed {
    logic       full;
    logic       empty;
    logic       overflow;
    logic [3:0] level;
  } tx_stat_t;

endpackage

// ==== source/tx_fifo.sv ====
// transmit byte FIFO
`timescale 1ns/1ps

module tx_fifo import periph_pkg::*; #(
  parameter int FifoDepth = 8
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       push,
  input  logic [7:0] push_data,
  input  logic       ovf_clear,
  input  logic       pop,
  output logic       have_data,
  output logic [7:0] data,
  output tx_stat_t   stat
);

  localparam int PtrWidth = $clog2(FifoDepth);

  logic [7:0]          mem [FifoDepth];
  logic [PtrWidth-1:0] wr_ptr;
  logic [PtrWidth-1:0] rd_ptr;
  logic [PtrWidth:0]   count;
  logic                overflow;
  logic                full;
  logic                do_push;
  logic                do_pop;

  assign full    = (count == (PtrWidth + 1)'(FifoDepth));
  assign do_push = push && !full;
  assign do_pop  = pop && have_data;

  assign have_data = (count != '0);
  assign data      = mem[rd_ptr];

  assign stat.full     = full;
  assign stat.empty    = !have_data;
  assign stat.overflow = overflow;
  assign stat.level    = 4'(count);

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      // pointers wrap explicitly, depth need not be a power of two
      if (do_push) begin
        wr_ptr <= (wr_ptr == PtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + (PtrWidth + 1)'(do_push) - (PtrWidth + 1)'(do_pop);
      // a dropped byte wins over a clear in the same cycle
      if (push && full) begin
        overflow <= 1'b1;
      end else if (ovf_clear) begin
        overflow <= 1'b0;
      end
    end
  end

endmodule

// ==== source/uart_tx.sv ====
// UART 8N1 transmitter
`timescale 1ns/1ps

module uart_tx (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [15:0] divisor,
  input  logic        have_data,
  input  logic [7:0]  data,
  output logic        tx,
  output logic        next
);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } uart_state_t;

  uart_state_t state;
  logic [15:0] baud_cnt;
  logic [7:0]  shift;
  logic [2:0]  bit_idx;
  logic        bit_done;

  // byte is taken from the FIFO head as the frame starts
  assign next     = (state == st_idle) && have_data;
  assign bit_done = (baud_cnt == 16'd0);

  always_comb begin
    case (state)
      st_start: tx = 1'b0;
      st_data:  tx = shift[0];
      default:  tx = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= st_idle;
      baud_cnt <= 16'd0;
      shift    <= 8'd0;
      bit_idx  <= 3'd0;
    end else if (state == st_idle) begin
      if (have_data) begin
        state    <= st_start;
        shift    <= data;
        baud_cnt <= divisor;
      end
    end else if (!bit_done) begin
      baud_cnt <= baud_cnt - 16'd1;
    end else begin
      // each bit lasts divisor + 1 clocks
      baud_cnt <= divisor;
      case (state)
        st_start: begin
          state   <= st_data;
          bit_idx <= 3'd0;
        end
        st_data: begin
          shift   <= shift >> 1;
          bit_idx <= bit_idx + 3'd1;
          if (bit_idx == 3'd7) begin
            state <= st_stop;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== tb.f ====
+incdir+dv
source/csr_pkg.sv
source/periph_pkg.sv
source/csr_issue.sv
source/csr_cell.sv
source/csr_collect.sv
source/tx_fifo.sv
source/uart_tx.sv
source/csr_periph_top.sv
dv/csr_periph_tb.sv
